/* hw/apb_mbox_pkg.sv */
// mailbox package with bus widths, address map, register offsets, ID value and pipeline choice
package apb_mbox_pkg;

    // APB bus widths
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int STRB_W = DATA_W / BYTE_W;
    localparam int ADDR_W = 16;

    // shared RAM region, byte addressed
    localparam int RAM_ADDR_W = 12;
    // word index width, 1024 words
    localparam int RAM_WORD_W = RAM_ADDR_W - $clog2(STRB_W);

    // port A address map
    localparam logic [ADDR_W-1:0] REG_BASE = 16'h1000;

    // register offsets from REG_BASE
    localparam logic [ADDR_W-1:0] REG_ID_OFS = 16'h0000;
    localparam logic [ADDR_W-1:0] REG_SCRATCH_OFS = 16'h0004;
    localparam logic [ADDR_W-1:0] REG_DOORBELL_OFS = 16'h0008;
    // write one to clear doorbell bits
    localparam logic [ADDR_W-1:0] REG_DOORBELL_CLR_OFS = 16'h000C;

    // value returned by the ID register
    localparam logic [DATA_W-1:0] MBOX_ID = 32'h4D42_0001;

    // extra output register stage in the RAM ports
    localparam bit RAM_PIPELINE = 1'b0;

endpackage

/* hw/apb_ram_port.sv */
// APB access sequencer for one RAM port with memory enables, ready pulse and output pipeline
`timescale 1ns/1ps

module apb_ram_port
    import apb_mbox_pkg::*;
(
    input  logic              a_clk,
    input  logic              a_rst,

    // requester control
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,

    // word currently addressed in the array
    input  logic [DATA_W-1:0] rd_word,

    // array enables for the accepting cycle
    output logic              wr_en,
    output logic              rd_en,

    // response toward the requester
    output logic [DATA_W-1:0] prdata,
    output logic              pready
);

    logic              accept;
    logic              ready_q;
    logic              ready_pipe_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] rdata_pipe_q;

    // one acceptance per access, held off while a ready is in flight
    assign accept = psel && penable && !ready_q && !(RAM_PIPELINE && ready_pipe_q);

    assign wr_en = accept && pwrite;
    assign rd_en = accept && !pwrite;

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            ready_q      <= 1'b0;
            ready_pipe_q <= 1'b0;
        end else begin
            ready_q      <= accept;
            ready_pipe_q <= ready_q;
        end
    end

    always_ff @(posedge a_clk) begin
        // capture the pre-write word of this cycle
        if (rd_en) begin
            rdata_q <= rd_word;
        end
        rdata_pipe_q <= rdata_q;
    end

    assign prdata = RAM_PIPELINE ? rdata_pipe_q : rdata_q;
    assign pready = RAM_PIPELINE ? ready_pipe_q : ready_q;

endmodule

/* hw/apb_dp_ram.sv */
// dual-port byte-strobed APB RAM with two access sequencers and port B collision priority
`timescale 1ns/1ps

module apb_dp_ram
    import apb_mbox_pkg::*;
(
    input  logic              a_clk,
    input  logic              a_rst,

    // port A completer
    input  logic              a_psel,
    input  logic              a_penable,
    input  logic              a_pwrite,
    input  logic [ADDR_W-1:0] a_paddr,
    input  logic [DATA_W-1:0] a_pwdata,
    input  logic [STRB_W-1:0] a_pstrb,
    output logic [DATA_W-1:0] a_prdata,
    output logic              a_pready,
    output logic              a_pslverr,

    // port B completer
    input  logic              b_psel,
    input  logic              b_penable,
    input  logic              b_pwrite,
    input  logic [ADDR_W-1:0] b_paddr,
    input  logic [DATA_W-1:0] b_pwdata,
    input  logic [STRB_W-1:0] b_pstrb,
    output logic [DATA_W-1:0] b_prdata,
    output logic              b_pready,
    output logic              b_pslverr
);

    logic [DATA_W-1:0] mem [2**RAM_WORD_W];

    logic [RAM_WORD_W-1:0] a_word;
    logic [RAM_WORD_W-1:0] b_word;

    logic [DATA_W-1:0] a_rd_word;
    logic [DATA_W-1:0] b_rd_word;

    logic a_wr_en;
    logic b_wr_en;

    // upper address bits dropped so addresses wrap
    assign a_word = a_paddr[RAM_ADDR_W-1 -: RAM_WORD_W];
    assign b_word = b_paddr[RAM_ADDR_W-1 -: RAM_WORD_W];

    // array contents start at zero
    initial begin
        for (int i = 0; i < 2**RAM_WORD_W; i++) begin
            mem[i] = '0;
        end
    end

    // port B lanes applied last so they win a collision
    always @(posedge a_clk) begin
        for (int i = 0; i < STRB_W; i++) begin
            if (a_wr_en && a_pstrb[i]) begin
                mem[a_word][BYTE_W*i +: BYTE_W] <= a_pwdata[BYTE_W*i +: BYTE_W];
            end
        end
        for (int i = 0; i < STRB_W; i++) begin
            if (b_wr_en && b_pstrb[i]) begin
                mem[b_word][BYTE_W*i +: BYTE_W] <= b_pwdata[BYTE_W*i +: BYTE_W];
            end
        end
    end

    // read side sees the value before this cycle's writes
    assign a_rd_word = mem[a_word];
    assign b_rd_word = mem[b_word];

    apb_ram_port port_a_i (
        .a_clk   (a_clk),
        .a_rst   (a_rst),
        .psel    (a_psel),
        .penable (a_penable),
        .pwrite  (a_pwrite),
        .rd_word (a_rd_word),
        .wr_en   (a_wr_en),
        .rd_en   (),
        .prdata  (a_prdata),
        .pready  (a_pready)
    );

    apb_ram_port port_b_i (
        .a_clk   (a_clk),
        .a_rst   (a_rst),
        .psel    (b_psel),
        .penable (b_penable),
        .pwrite  (b_pwrite),
        .rd_word (b_rd_word),
        .wr_en   (b_wr_en),
        .rd_en   (),
        .prdata  (b_prdata),
        .pready  (b_pready)
    );

    // the array never reports an error
    assign a_pslverr = 1'b0;
    assign b_pslverr = 1'b0;

endmodule

/* hw/apb_addr_split.sv */
// port A address decoder steering APB accesses to the RAM or the register block
`timescale 1ns/1ps

module apb_addr_split
    import apb_mbox_pkg::*;
(
    // requester side
    input  logic              psel,
    input  logic              penable,
    input  logic [ADDR_W-1:0] paddr,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,

    // RAM side
    output logic              ram_psel,
    output logic              ram_penable,
    input  logic [DATA_W-1:0] ram_prdata,
    input  logic              ram_pready,
    input  logic              ram_pslverr,

    // register side
    output logic              reg_psel,
    output logic              reg_penable,
    input  logic [DATA_W-1:0] reg_prdata,
    input  logic              reg_pready,
    input  logic              reg_pslverr
);

    logic hit_reg;

    // everything at or above REG_BASE belongs to the registers
    assign hit_reg = (paddr >= REG_BASE);

    assign ram_psel    = psel && !hit_reg;
    assign ram_penable = penable && !hit_reg;
    assign reg_psel    = psel && hit_reg;
    assign reg_penable = penable && hit_reg;

    // paddr is held through the access, so the response follows it
    always_comb begin
        if (hit_reg) begin
            prdata  = reg_prdata;
            pready  = reg_pready;
            pslverr = reg_pslverr;
        end else begin
            prdata  = ram_prdata;
            pready  = ram_pready;
            pslverr = ram_pslverr;
        end
    end

endmodule

/* hw/apb_mbox_regs.sv */
// mailbox ID, scratch and doorbell registers with interrupt output and unmapped offset error
`timescale 1ns/1ps

module apb_mbox_regs
    import apb_mbox_pkg::*;
(
    input  logic              a_clk,
    input  logic              a_rst,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    input  logic [STRB_W-1:0] pstrb,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,

    output logic              irq
);

    logic [ADDR_W-1:0] ofs;
    logic [DATA_W-1:0] wmask;
    logic [DATA_W-1:0] rd_value;
    logic              err;
    logic              accept;

    logic [DATA_W-1:0] scratch_q;
    logic [DATA_W-1:0] doorbell_q;
    logic [DATA_W-1:0] prdata_q;
    logic              pready_q;
    logic              pslverr_q;

    assign ofs    = paddr - REG_BASE;
    assign accept = psel && penable && !pready_q;

    // byte strobes widened to a bit mask
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            wmask[BYTE_W*i +: BYTE_W] = {BYTE_W{pstrb[i]}};
        end
    end

    always_comb begin
        rd_value = '0;
        err      = 1'b0;
        case (ofs)
            REG_ID_OFS: begin
                rd_value = MBOX_ID;
                // ID is read only
                err      = pwrite;
            end
            REG_SCRATCH_OFS: rd_value = scratch_q;
            REG_DOORBELL_OFS: rd_value = doorbell_q;
            REG_DOORBELL_CLR_OFS: rd_value = doorbell_q;
            default: err = 1'b1;
        endcase
    end

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            scratch_q  <= '0;
            doorbell_q <= '0;
            pready_q   <= 1'b0;
            pslverr_q  <= 1'b0;
        end else begin
            pready_q <= accept;
            if (accept) begin
                pslverr_q <= err;
            end
            if (accept && pwrite && !err) begin
                case (ofs)
                    REG_SCRATCH_OFS: scratch_q <= (scratch_q & ~wmask) | (pwdata & wmask);
                    // set bits written as one
                    REG_DOORBELL_OFS: doorbell_q <= doorbell_q | (pwdata & wmask);
                    // clear bits written as one
                    REG_DOORBELL_CLR_OFS: doorbell_q <= doorbell_q & ~(pwdata & wmask);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge a_clk) begin
        if (accept) begin
            prdata_q <= pwrite ? '0 : rd_value;
        end
    end

    assign prdata  = prdata_q;
    assign pready  = pready_q;
    assign pslverr = pslverr_q;

    // pending doorbell raises the interrupt
    assign irq = |doorbell_q;

endmodule

/* hw/apb_mbox_top.sv */
// mailbox top level connecting the port A split, the register block and the dual-port RAM
`timescale 1ns/1ps

module apb_mbox_top
    import apb_mbox_pkg::*;
(
    input  logic              a_clk,
    input  logic              a_rst,

    // port A requester
    input  logic              a_psel,
    input  logic              a_penable,
    input  logic              a_pwrite,
    input  logic [ADDR_W-1:0] a_paddr,
    input  logic [DATA_W-1:0] a_pwdata,
    input  logic [STRB_W-1:0] a_pstrb,
    output logic [DATA_W-1:0] a_prdata,
    output logic              a_pready,
    output logic              a_pslverr,

    // port B requester
    input  logic              b_psel,
    input  logic              b_penable,
    input  logic              b_pwrite,
    input  logic [ADDR_W-1:0] b_paddr,
    input  logic [DATA_W-1:0] b_pwdata,
    input  logic [STRB_W-1:0] b_pstrb,
    output logic [DATA_W-1:0] b_prdata,
    output logic              b_pready,
    output logic              b_pslverr,

    output logic              irq
);

    logic              ram_a_psel;
    logic              ram_a_penable;
    logic [DATA_W-1:0] ram_a_prdata;
    logic              ram_a_pready;
    logic              ram_a_pslverr;

    logic              reg_psel;
    logic              reg_penable;
    logic [DATA_W-1:0] reg_prdata;
    logic              reg_pready;
    logic              reg_pslverr;

    apb_addr_split split_i (
        .psel        (a_psel),
        .penable     (a_penable),
        .paddr       (a_paddr),
        .prdata      (a_prdata),
        .pready      (a_pready),
        .pslverr     (a_pslverr),
        .ram_psel    (ram_a_psel),
        .ram_penable (ram_a_penable),
        .ram_prdata  (ram_a_prdata),
        .ram_pready  (ram_a_pready),
        .ram_pslverr (ram_a_pslverr),
        .reg_psel    (reg_psel),
        .reg_penable (reg_penable),
        .reg_prdata  (reg_prdata),
        .reg_pready  (reg_pready),
        .reg_pslverr (reg_pslverr)
    );

    // write controls and data fan out directly
    apb_mbox_regs regs_i (
        .a_clk   (a_clk),
        .a_rst   (a_rst),
        .psel    (reg_psel),
        .penable (reg_penable),
        .pwrite  (a_pwrite),
        .paddr   (a_paddr),
        .pwdata  (a_pwdata),
        .pstrb   (a_pstrb),
        .prdata  (reg_prdata),
        .pready  (reg_pready),
        .pslverr (reg_pslverr),
        .irq     (irq)
    );

    apb_dp_ram ram_i (
        .a_clk     (a_clk),
        .a_rst     (a_rst),
        .a_psel    (ram_a_psel),
        .a_penable (ram_a_penable),
        .a_pwrite  (a_pwrite),
        .a_paddr   (a_paddr),
        .a_pwdata  (a_pwdata),
        .a_pstrb   (a_pstrb),
        .a_prdata  (ram_a_prdata),
        .a_pready  (ram_a_pready),
        .a_pslverr (ram_a_pslverr),
        .b_psel    (b_psel),
        .b_penable (b_penable),
        .b_pwrite  (b_pwrite),
        .b_paddr   (b_paddr),
        .b_pwdata  (b_pwdata),
        .b_pstrb   (b_pstrb),
        .b_prdata  (b_prdata),
        .b_pready  (b_pready),
        .b_pslverr (b_pslverr)
    );

endmodule

/* verification/tb_apb_tasks.svh */
// APB request drive, access and collision tasks with the reference memory model

// shadow of the RAM contents, updated on every RAM write
logic [DATA_W-1:0] ref_mem [2**RAM_WORD_W];

// addresses wrap modulo the RAM size
function automatic int word_index(input logic [ADDR_W-1:0] addr);
    return int'(addr[RAM_ADDR_W-1:$clog2(STRB_W)]);
endfunction

task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb);
    // only the enabled byte lanes change
    for (int i = 0; i < STRB_W; i++) begin
        if (strb[i]) begin
            ref_mem[word_index(addr)][BYTE_W*i +: BYTE_W] = wdata[BYTE_W*i +: BYTE_W];
        end
    end
endtask

task automatic set_request(input int port, input logic sel, input logic en, input logic wr,
        input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb);
    if (port == PORT_A) begin
        a_psel    <= sel;
        a_penable <= en;
        a_pwrite  <= wr;
        a_paddr   <= addr;
        a_pwdata  <= wdata;
        a_pstrb   <= strb;
    end else begin
        b_psel    <= sel;
        b_penable <= en;
        b_pwrite  <= wr;
        b_paddr   <= addr;
        b_pwdata  <= wdata;
        b_pstrb   <= strb;
    end
endtask

task automatic apb_access(input int port, input logic wr, input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
        output logic [DATA_W-1:0] rdata, output logic err, output logic got_ready);
    int waited;
    // setup phase, then access phase held until pready
    @(posedge a_clk);
    set_request(port, 1'b1, 1'b0, wr, addr, wdata, strb);
    @(posedge a_clk);
    set_request(port, 1'b1, 1'b1, wr, addr, wdata, strb);
    waited    = 0;
    got_ready = 1'b0;
    while (!got_ready && waited < ACCESS_WAIT) begin
        @(negedge a_clk);
        waited++;
        got_ready = ((port == PORT_A) ? a_pready : b_pready) === 1'b1;
    end
    rdata = (port == PORT_A) ? a_prdata : b_prdata;
    err   = (port == PORT_A) ? a_pslverr : b_pslverr;
    // transfer completes on the next rising edge
    @(posedge a_clk);
    set_request(port, 1'b0, 1'b0, wr, addr, wdata, strb);
endtask

task automatic collide_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] a_data,
        input logic [DATA_W-1:0] b_data, output logic both_ready);
    @(posedge a_clk);
    set_request(PORT_A, 1'b1, 1'b0, 1'b1, addr, a_data, '1);
    set_request(PORT_B, 1'b1, 1'b0, 1'b1, addr, b_data, '1);
    @(posedge a_clk);
    set_request(PORT_A, 1'b1, 1'b1, 1'b1, addr, a_data, '1);
    set_request(PORT_B, 1'b1, 1'b1, 1'b1, addr, b_data, '1);
    // fixed RAM latency puts both ready pulses in the same cycle
    repeat (1 + RAM_PIPELINE) @(posedge a_clk);
    @(negedge a_clk);
    both_ready = (a_pready === 1'b1) && (b_pready === 1'b1);
    @(posedge a_clk);
    set_request(PORT_A, 1'b0, 1'b0, 1'b1, addr, a_data, '1);
    set_request(PORT_B, 1'b0, 1'b0, 1'b1, addr, b_data, '1);
endtask

/* verification/tb_apb_mbox_top.sv */
// testbench for the APB mailbox with clock, reset, watchdog, test table loop and report
`timescale 1ns/1ps

module tb_apb_mbox_top
    import apb_mbox_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int ACCESS_WAIT  = 8;
    localparam int PORT_A       = 0;
    localparam int PORT_B       = 1;
    localparam int PORT_BOTH    = 2;

    // for PORT_BOTH the exp_data field holds the port B write data
    typedef struct packed {
        int                port;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] exp_data;
        logic              exp_err;
        int                exp_irq;
    } test_t;

    logic              a_clk, a_rst, irq;
    logic              a_psel, a_penable, a_pwrite, a_pready, a_pslverr;
    logic              b_psel, b_penable, b_pwrite, b_pready, b_pslverr;
    logic [ADDR_W-1:0] a_paddr, b_paddr;
    logic [DATA_W-1:0] a_pwdata, a_prdata, b_pwdata, b_prdata;
    logic [STRB_W-1:0] a_pstrb, b_pstrb;

    test_t  tests[$];
    bit     table_built;
    integer seed = 37818;
    int     pass_count;
    int     fail_count;

    apb_mbox_top dut_i (.*);

    `include "tb_apb_tasks.svh"

    task automatic add_test(input int port, input logic wr, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
            input logic [DATA_W-1:0] exp_data, input logic exp_err, input int exp_irq);
        test_t t;
        t.port     = port;
        t.wr       = wr;
        t.addr     = addr;
        t.data     = data;
        t.strb     = strb;
        t.exp_data = exp_data;
        t.exp_err  = exp_err;
        t.exp_irq  = exp_irq;
        tests.push_back(t);
    endtask

    task automatic build_table();
        logic [ADDR_W-1:0] addrs [64];
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        // full words cross between the ports
        add_test(PORT_A, 1, 16'h0100, 32'hCAFE_0100, 4'hF, '0, 0, -1);
        add_test(PORT_B, 0, 16'h0100, '0, '0, '0, 0, -1);
        add_test(PORT_B, 1, 16'h0204, 32'h5A5A_1234, 4'hF, '0, 0, -1);
        add_test(PORT_A, 0, 16'h0204, '0, '0, '0, 0, -1);
        // partial strobes merge into the old word
        add_test(PORT_A, 1, 16'h0300, 32'h1122_3344, 4'hF, '0, 0, -1);
        add_test(PORT_A, 1, 16'h0300, 32'hAABB_CCDD, 4'b0110, '0, 0, -1);
        add_test(PORT_B, 1, 16'h0300, 32'h9988_7766, 4'b1000, '0, 0, -1);
        add_test(PORT_A, 0, 16'h0300, '0, '0, '0, 0, -1);
        add_test(PORT_B, 0, 16'h0300, '0, '0, '0, 0, -1);
        // ID, scratch and error responses of the register block
        add_test(PORT_A, 0, 16'h1000, '0, '0, MBOX_ID, 0, -1);
        add_test(PORT_A, 1, 16'h1000, 32'hFFFF_FFFF, 4'hF, '0, 1, -1);
        add_test(PORT_A, 1, 16'h1004, 32'h1122_3344, 4'hF, '0, 0, -1);
        add_test(PORT_A, 1, 16'h1004, 32'hAABB_CCDD, 4'b0101, '0, 0, -1);
        add_test(PORT_A, 0, 16'h1004, '0, '0, 32'h11BB_33DD, 0, -1);
        add_test(PORT_A, 0, 16'h1010, '0, '0, '0, 1, -1);
        add_test(PORT_A, 1, 16'h1020, 32'h0000_0001, 4'hF, '0, 1, -1);
        // doorbell set and clear with the interrupt
        add_test(PORT_A, 0, 16'h1008, '0, '0, '0, 0, 0);
        add_test(PORT_A, 1, 16'h1008, 32'h0000_00A5, 4'hF, '0, 0, 1);
        add_test(PORT_A, 0, 16'h1008, '0, '0, 32'h0000_00A5, 0, 1);
        add_test(PORT_A, 1, 16'h100C, 32'h0000_00A5, 4'hF, '0, 0, 0);
        add_test(PORT_A, 0, 16'h1008, '0, '0, '0, 0, 0);
        // same word written by both ports in one cycle
        add_test(PORT_BOTH, 1, 16'h0400, 32'h1111_AAAA, 4'hF, 32'h2222_5555, 0, -1);
        add_test(PORT_A, 0, 16'h0400, '0, '0, '0, 0, -1);
        add_test(PORT_B, 0, 16'h0400, '0, '0, '0, 0, -1);
        // random writes alternate ports, port B may use wrapping addresses
        for (int i = 0; i < 64; i++) begin
            addrs[i] = $random(seed);
            addrs[i] = addrs[i] & ((i % 2 == 0) ? 16'h0FFC : 16'hFFFC);
            wdata    = $random(seed);
            strb     = $random(seed);
            add_test(i % 2, 1, addrs[i], wdata, strb, '0, 0, -1);
        end
        for (int i = 0; i < 64; i++) begin
            add_test((i + 1) % 2, 0, addrs[i] & 16'h0FFC, '0, '0, '0, 0, -1);
        end
    endtask

    initial begin
        a_clk = 1'b0;
        forever #(CLK_PERIOD / 2) a_clk = ~a_clk;
    end

    initial begin
        wait (table_built);
        repeat (tests.size() * 20 + RESET_CYCLES) @(posedge a_clk);
        $display("watchdog: run did not finish within %0d clock cycles",
                 tests.size() * 20 + RESET_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        test_t             t;
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] expect_data;
        logic              err;
        logic              got_ready;
        bit                ram_hit;
        bit                ok;

        a_rst = 1'b1;
        {a_psel, a_penable, a_pwrite, a_paddr, a_pwdata, a_pstrb} = '0;
        {b_psel, b_penable, b_pwrite, b_paddr, b_pwdata, b_pstrb} = '0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0;
        end
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge a_clk);
        a_rst <= 1'b0;

        foreach (tests[i]) begin
            t       = tests[i];
            ok      = 1'b1;
            ram_hit = (t.port != PORT_A) || (t.addr < REG_BASE);
            err     = 1'b0;
            rdata   = '0;
            if (t.port == PORT_BOTH) begin
                collide_write(t.addr, t.data, t.exp_data, got_ready);
                // port B lanes land last
                model_write(t.addr, t.data, t.strb);
                model_write(t.addr, t.exp_data, t.strb);
            end else begin
                apb_access(t.port, t.wr, t.addr, t.data, t.strb, rdata, err, got_ready);
                if (t.wr && ram_hit) begin
                    model_write(t.addr, t.data, t.strb);
                end
            end
            expect_data = ram_hit ? ref_mem[word_index(t.addr)] : t.exp_data;
            if (!got_ready) begin
                $display("test %0d: pready missing or not in the expected cycle", i);
                ok = 1'b0;
            end else if (t.port != PORT_BOTH) begin
                if (err !== t.exp_err) begin
                    $display("ERR %0t test %0d: pslverr %b expected %b", $time, i, err, t.exp_err);
                    ok = 1'b0;
                end
                if (!t.wr && rdata !== expect_data) begin
                    $display("ERR %0t test %0d: prdata %h expected %h", $time, i, rdata,
                             expect_data);
                    ok = 1'b0;
                end
            end
            if (t.exp_irq >= 0 && irq !== t.exp_irq[0]) begin
                $display("ERR %0t test %0d: irq %b expected %b", $time, i, irq, t.exp_irq[0]);
                ok = 1'b0;
            end
            $display("test %0d port %s %s addr %h: %s", i,
                     (t.port == PORT_A) ? "A" : (t.port == PORT_B) ? "B" : "A+B",
                     t.wr ? "write" : "read", t.addr, ok ? "ok" : "FAIL");
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
        end

        $display("summary: %0d run, %0d passed, %0d failed", tests.size(), pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verification
hw/apb_mbox_pkg.sv
hw/apb_ram_port.sv
hw/apb_dp_ram.sv
hw/apb_addr_split.sv
hw/apb_mbox_regs.sv
hw/apb_mbox_top.sv
verification/tb_apb_mbox_top.sv

/* Bender.yml */
package:
  name: apb_mbox

sources:
  - hw/apb_mbox_pkg.sv
  - hw/apb_ram_port.sv
  - hw/apb_dp_ram.sv
  - hw/apb_addr_split.sv
  - hw/apb_mbox_regs.sv
  - hw/apb_mbox_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_apb_mbox_top.sv
